// ==== Bender.yml ====
package:
  name: seed_queue

sources:
  - files:
      - occ_pkg.sv
      - seed_pkg.sv
      - query_wait_pipe.sv
      - occ_response_fifo.sv
      - read_queue_dispatch.sv
      - seed_queue.sv
  - target: test
    files:
      - tb_seed_queue_sva.sv
      - tb_seed_queue.sv

// ==== occ_pkg.sv ====
/*
 * Occurrence-count response format returned by DRAM, plus the depth of
 * the response FIFO that buffers it ahead of the dispatcher.
 */
package occ_pkg;

	//==================================================
	// response FIFO sizing
	//==================================================
	localparam int OCC_Q_DEPTH = 32;
	localparam int OCC_AW      = $clog2(OCC_Q_DEPTH); // no wrap bit, pointers wrap with the RAM

	localparam int CNT_A_W = 32;
	localparam int CNT_B_W = 64;
	localparam int N_BASES = 4;  // A C G T

	// one occurrence-count response, 768 bits
	typedef struct packed {
		logic [N_BASES-1:0][CNT_A_W-1:0] cnt_a;
		logic [N_BASES-1:0][CNT_B_W-1:0] cnt_b;
		logic [N_BASES-1:0][CNT_A_W-1:0] cntl_a;
		logic [N_BASES-1:0][CNT_B_W-1:0] cntl_b;
	} occ_resp_t;

endpackage

// ==== occ_response_fifo.sv ====
/*
 * Circular FIFO for DRAM occurrence-count responses. Writes are taken even
 * under stall; the head word is re-registered on every stall-free cycle.
 */
module occ_response_fifo (
	input  logic               Clk_32UI,
	input  logic               reset_n,
	input  logic               stall,
	input  logic               DRAM_get,
	input  occ_pkg::occ_resp_t occ_in,
	input  logic               occ_pop,
	output logic               occ_valid,
	output occ_pkg::occ_resp_t occ_head
);

	occ_pkg::occ_resp_t          occ_mem [occ_pkg::OCC_Q_DEPTH];
	logic [occ_pkg::OCC_AW-1:0]  wr_ptr;
	logic [occ_pkg::OCC_AW-1:0]  rd_ptr;

	//==================================================
	// write side, independent of stall
	//==================================================
	always_ff @(posedge Clk_32UI) begin
		if (DRAM_get)
			occ_mem[wr_ptr] <= occ_in;
	end

	always_ff @(posedge Clk_32UI) begin
		if (!reset_n)
			wr_ptr <= '0;
		else if (DRAM_get)
			wr_ptr <= wr_ptr + 1'b1;
	end

	//==================================================
	// read side
	//==================================================
	// dispatcher only pops on stall-free cycles
	always_ff @(posedge Clk_32UI) begin
		if (!reset_n)
			rd_ptr <= '0;
		else if (occ_pop)
			rd_ptr <= rd_ptr + 1'b1;
	end

	// word at rd_ptr before the pop, so it lines up one stage behind the decision
	always_ff @(posedge Clk_32UI) begin
		if (!stall)
			occ_head <= occ_mem[rd_ptr];
	end

	assign occ_valid = (wr_ptr != rd_ptr); // not empty

endmodule

// ==== query_wait_pipe.sv ====
/*
 * Holds each forward record for the read RAM latency, then joins it with
 * the returned query base and offers the finished entry to the read queue.
 */
module query_wait_pipe (
	input  logic               Clk_32UI,
	input  logic               reset_n,
	input  logic               stall,
	input  seed_pkg::fwd_rec_t fwd_in,
	input  seed_pkg::status_t  fwd_status,
	input  seed_pkg::base_t    new_read_query_2Queue,
	output seed_pkg::fwd_entry_t entry,
	output logic               entry_write
);

	localparam int LAST = seed_pkg::QUERY_WAIT - 1;

	seed_pkg::fwd_rec_t rec_pipe [seed_pkg::QUERY_WAIT];
	seed_pkg::status_t  st_pipe  [seed_pkg::QUERY_WAIT];
	logic               last_is_fwd;

	//==================================================
	// wait stages while the base is fetched
	//==================================================
	always_ff @(posedge Clk_32UI) begin
		if (!stall) begin
			rec_pipe[0] <= fwd_in;
			for (int i = 1; i < seed_pkg::QUERY_WAIT; i++) begin
				rec_pipe[i] <= rec_pipe[i-1];
			end
		end
	end

	always_ff @(posedge Clk_32UI) begin
		if (!reset_n) begin
			for (int i = 0; i < seed_pkg::QUERY_WAIT; i++) begin
				st_pipe[i] <= seed_pkg::BUBBLE;
			end
		end else if (!stall) begin
			st_pipe[0] <= fwd_status;
			for (int i = 1; i < seed_pkg::QUERY_WAIT; i++) begin
				st_pipe[i] <= st_pipe[i-1];
			end
		end
	end

	// only forward codes go into the queue
	assign last_is_fwd = (st_pipe[LAST] == seed_pkg::F_INIT) ||
		(st_pipe[LAST] == seed_pkg::F_RUN) ||
		(st_pipe[LAST] == seed_pkg::F_BREAK);

	//==================================================
	// join stage, base arrives this cycle
	//==================================================
	always_ff @(posedge Clk_32UI) begin
		if (!stall) begin
			entry.rec    <= rec_pipe[LAST];
			entry.query  <= new_read_query_2Queue;
			entry.status <= st_pipe[LAST];
		end
	end

	always_ff @(posedge Clk_32UI) begin
		if (!reset_n)
			entry_write <= 1'b0;
		else if (!stall)
			entry_write <= last_is_fwd;
	end

endmodule

// ==== read_queue_dispatch.sv ====
/*
 * Circular read queue and dispatcher. Chooses each cycle between a break
 * pop, a fresh read and a run pop with its occurrence word, over two stages.
 */
module read_queue_dispatch (
	input  logic                 Clk_32UI,
	input  logic                 reset_n,
	input  logic                 stall,
	input  seed_pkg::fwd_entry_t entry,
	input  logic                 entry_write,
	input  logic                 occ_valid,
	input  occ_pkg::occ_resp_t   occ_head,
	input  logic                 new_read_valid,
	input  seed_pkg::new_read_t  new_rd,
	output logic                 new_read,
	output logic                 occ_pop,
	output seed_pkg::fwd_out_t   fwd_out,
	output occ_pkg::occ_resp_t   occ_out
);

	seed_pkg::fwd_entry_t           q_mem [seed_pkg::READ_Q_DEPTH];
	logic [seed_pkg::READ_Q_PW-1:0] wr_ptr;
	logic [seed_pkg::READ_Q_PW-1:0] rd_ptr;

	seed_pkg::fwd_entry_t head;
	seed_pkg::status_t    head_status;
	seed_pkg::fwd_entry_t fresh;
	logic                 take_break;
	logic                 take_new;
	logic                 take_run;

	seed_pkg::fwd_entry_t s1;   // first output stage
	logic [63:0]          k_next;

	//==================================================
	// circular read queue
	//==================================================
	always_ff @(posedge Clk_32UI) begin
		if (!stall && entry_write)
			q_mem[wr_ptr[seed_pkg::READ_Q_AW-1:0]] <= entry;
	end

	always_ff @(posedge Clk_32UI) begin
		if (!reset_n)
			wr_ptr <= '0;
		else if (!stall && entry_write)
			wr_ptr <= wr_ptr + 1'b1;
	end

	always_ff @(posedge Clk_32UI) begin
		if (!reset_n)
			rd_ptr <= '0;
		else if (!stall && (take_break || take_run))
			rd_ptr <= rd_ptr + 1'b1;
	end

	assign head        = q_mem[rd_ptr[seed_pkg::READ_Q_AW-1:0]];
	assign head_status = (wr_ptr != rd_ptr) ? head.status : seed_pkg::BUBBLE;

	//==================================================
	// arbitration
	//==================================================
	// break first, then a new read, then run with its response
	always_comb begin
		take_break = (head_status == seed_pkg::F_BREAK);
		take_new   = !take_break && new_read_valid;
		take_run   = !take_break && !new_read_valid && occ_valid &&
			(head_status == seed_pkg::F_RUN);
	end

	assign new_read = new_read_valid && !stall && (head_status != seed_pkg::F_BREAK);
	assign occ_pop  = take_run && !stall;

	// fresh read starts at ptr 0, no query needed in the first round
	always_comb begin
		fresh.rec.ptr_curr   = '0;
		fresh.rec.read_num   = new_rd.read_num;
		fresh.rec.ik_x0      = new_rd.ik_x0;
		fresh.rec.ik_x1      = new_rd.ik_x1;
		fresh.rec.ik_x2      = new_rd.ik_x2;
		fresh.rec.ik_info_hi = new_rd.ik_info_hi;
		fresh.rec.ik_info_lo = new_rd.ik_info_lo;
		fresh.rec.forward_i  = new_rd.forward_i + 1'b1;
		fresh.rec.min_intv   = new_rd.min_intv;
		fresh.rec.backward_x = new_rd.forward_i;
		fresh.query          = '0;
		fresh.status         = seed_pkg::F_INIT;
	end

	//==================================================
	// stage 1, decision
	//==================================================
	always_ff @(posedge Clk_32UI) begin
		if (!reset_n) begin
			s1.status <= seed_pkg::BUBBLE;
		end else if (!stall) begin
			if (take_break || take_run)
				s1 <= head;
			else if (take_new)
				s1 <= fresh;
			else
				s1.status <= seed_pkg::BUBBLE; // nothing to send
		end
	end

	//==================================================
	// stage 2, k/l and occurrence alignment
	//==================================================
	assign k_next = 64'(s1.rec.ik_x1) - 64'd1;

	always_ff @(posedge Clk_32UI) begin
		if (!reset_n) begin
			fwd_out.entry.status <= seed_pkg::BUBBLE;
		end else if (!stall) begin
			fwd_out.entry     <= s1;
			fwd_out.forward_k <= k_next;
			fwd_out.forward_l <= k_next + 64'(s1.rec.ik_x2);
		end
	end

	// head word already reflects the pop from stage 1
	always_ff @(posedge Clk_32UI) begin
		if (!stall)
			occ_out <= occ_head;
	end

endmodule

// ==== seed_pkg.sv ====
/*
 * Read record layout, status codes and queue sizing for the forward
 * seeding read queue. Referenced by scoped name from every RTL module.
 */
package seed_pkg;

	//==================================================
	// field widths
	//==================================================
	localparam int READ_NUM_W = 10;
	localparam int POS_W      = 7;   // positions, counts, ik_info halves
	localparam int INTV_W     = 33;  // SA interval bounds as kept in the queue
	localparam int BASE_W     = 8;
	localparam int STATUS_W   = 6;

	// read queue sizing, cut down for simulation
	localparam int READ_Q_DEPTH = 64;
	localparam int READ_Q_AW    = $clog2(READ_Q_DEPTH);
	localparam int READ_Q_PW    = READ_Q_AW + 1; // extra wrap bit

	localparam int QUERY_WAIT = 3; // read RAM latency in stall-free cycles

	typedef logic [STATUS_W-1:0] status_t;
	typedef logic [BASE_W-1:0]   base_t;

	// one-hot status, backward codes not carried here
	localparam status_t F_INIT  = 6'b00_0001;
	localparam status_t F_RUN   = 6'b00_0010;
	localparam status_t F_BREAK = 6'b00_0100;
	localparam status_t BUBBLE  = 6'b00_0000;

	//==================================================
	// records
	//==================================================
	typedef struct packed {
		logic [POS_W-1:0]      ptr_curr;
		logic [READ_NUM_W-1:0] read_num;
		logic [INTV_W-1:0]     ik_x0;
		logic [INTV_W-1:0]     ik_x1;
		logic [INTV_W-1:0]     ik_x2;
		logic [POS_W-1:0]      ik_info_hi; // ik_info[38:32]
		logic [POS_W-1:0]      ik_info_lo; // ik_info[6:0]
		logic [POS_W-1:0]      forward_i;
		logic [POS_W-1:0]      min_intv;
		logic [POS_W-1:0]      backward_x;
	} fwd_rec_t;

	// one read queue slot
	typedef struct packed {
		fwd_rec_t rec;
		base_t    query;
		status_t  status;
	} fwd_entry_t;

	// fresh read from the loader
	typedef struct packed {
		logic [READ_NUM_W-1:0] read_num;
		logic [INTV_W-1:0]     ik_x0;
		logic [INTV_W-1:0]     ik_x1;
		logic [INTV_W-1:0]     ik_x2;
		logic [POS_W-1:0]      ik_info_hi;
		logic [POS_W-1:0]      ik_info_lo;
		logic [POS_W-1:0]      forward_i;
		logic [POS_W-1:0]      min_intv;
	} new_read_t;

	typedef struct packed {
		fwd_entry_t  entry;
		logic [63:0] forward_k;
		logic [63:0] forward_l;
	} fwd_out_t;

endpackage

// ==== seed_queue.f ====
occ_pkg.sv
seed_pkg.sv
query_wait_pipe.sv
occ_response_fifo.sv
read_queue_dispatch.sv
seed_queue.sv
tb_seed_queue_sva.sv
tb_seed_queue.sv

// ==== seed_queue.sv ====
/*
 * Top level of the forward read queue. Connects the query wait pipe, the
 * occurrence FIFO and the dispatcher, and passes query requests to the read RAM.
 */
module seed_queue (
	input  logic                           Clk_32UI,
	input  logic                           reset_n,
	input  logic                           stall,
	input  logic                           DRAM_get,
	input  occ_pkg::occ_resp_t             occ_in,
	input  seed_pkg::fwd_rec_t             fwd_in,
	input  seed_pkg::status_t              fwd_status,
	input  logic [seed_pkg::POS_W-1:0]      next_query_position,
	input  logic [seed_pkg::READ_NUM_W-1:0] read_num_query,
	input  seed_pkg::status_t              status_query,
	input  seed_pkg::base_t                new_read_query_2Queue,
	input  logic                           new_read_valid,
	input  seed_pkg::new_read_t            new_rd,
	output logic                           new_read,
	output logic [seed_pkg::POS_W-1:0]      query_position_2RAM,
	output logic [seed_pkg::READ_NUM_W-1:0] query_read_num_2RAM,
	output seed_pkg::status_t              query_status_2RAM,
	output seed_pkg::fwd_out_t             fwd_out,
	output occ_pkg::occ_resp_t             occ_out
);

	seed_pkg::fwd_entry_t entry;
	logic                 entry_write;
	logic                 occ_valid;
	logic                 occ_pop;
	occ_pkg::occ_resp_t   occ_head;

	// forward query straight to the read RAM
	assign query_position_2RAM = next_query_position;
	assign query_read_num_2RAM = read_num_query;
	assign query_status_2RAM   = status_query;

	query_wait_pipe query_wait_pipe_inst (
		.Clk_32UI              (Clk_32UI),
		.reset_n               (reset_n),
		.stall                 (stall),
		.fwd_in                (fwd_in),
		.fwd_status            (fwd_status),
		.new_read_query_2Queue (new_read_query_2Queue),
		.entry                 (entry),
		.entry_write           (entry_write)
	);

	occ_response_fifo occ_response_fifo_inst (
		.Clk_32UI  (Clk_32UI),
		.reset_n   (reset_n),
		.stall     (stall),
		.DRAM_get  (DRAM_get),
		.occ_in    (occ_in),
		.occ_pop   (occ_pop),
		.occ_valid (occ_valid),
		.occ_head  (occ_head)
	);

	read_queue_dispatch read_queue_dispatch_inst (
		.Clk_32UI       (Clk_32UI),
		.reset_n        (reset_n),
		.stall          (stall),
		.entry          (entry),
		.entry_write    (entry_write),
		.occ_valid      (occ_valid),
		.occ_head       (occ_head),
		.new_read_valid (new_read_valid),
		.new_rd         (new_rd),
		.new_read       (new_read),
		.occ_pop        (occ_pop),
		.fwd_out        (fwd_out),
		.occ_out        (occ_out)
	);

endmodule

// ==== tb_seed_queue.sv ====
/*
 * Testbench for the forward read queue. Feeds records, bases, fresh reads
 * and DRAM responses, and checks each dispatched record against a model.
 */
module tb_seed_queue;
	timeunit 1ns;
	timeprecision 100ps;

	logic                            Clk_32UI;
	logic                            reset_n;
	logic                            stall;
	logic                            DRAM_get;
	occ_pkg::occ_resp_t              occ_in;
	seed_pkg::fwd_rec_t              fwd_in;
	seed_pkg::status_t               fwd_status;
	logic [seed_pkg::POS_W-1:0]      next_query_position;
	logic [seed_pkg::READ_NUM_W-1:0] read_num_query;
	seed_pkg::status_t               status_query;
	seed_pkg::base_t                 new_read_query_2Queue;
	logic                            new_read_valid;
	seed_pkg::new_read_t             new_rd;
	logic                            new_read;
	logic [seed_pkg::POS_W-1:0]      query_position_2RAM;
	logic [seed_pkg::READ_NUM_W-1:0] query_read_num_2RAM;
	seed_pkg::status_t               query_status_2RAM;
	seed_pkg::fwd_out_t              fwd_out;
	occ_pkg::occ_resp_t              occ_out;

	seed_pkg::base_t query_base;   // base the read RAM will return for the record
	seed_pkg::base_t base_dly1;
	seed_pkg::base_t base_dly2;

	//==================================================
	// model state
	//==================================================
	seed_pkg::fwd_entry_t read_q[$];   // queued records in push order
	seed_pkg::fwd_entry_t fresh_q[$];  // fresh reads taken on new_read
	occ_pkg::occ_resp_t   occ_q[$];

	integer seed       = 32'h7f0da443;
	int     err_cnt    = 0;
	int     chk_cnt    = 0;
	int     nr_gap_cnt = 0;
	logic   out_fresh  = 1'b0;
	logic   timed_out  = 1'b0;

	seed_queue seed_queue_inst (.*);

	initial begin
		Clk_32UI = 1'b0;
		forever #2 Clk_32UI = ~Clk_32UI;
	end

	// read RAM model answering three stall-free cycles after the record
	always @(posedge Clk_32UI) begin
		if (!stall) begin
			base_dly1             <= query_base;
			base_dly2             <= base_dly1;
			new_read_query_2Queue <= base_dly2;
		end
	end

	function automatic logic [799:0] rand_bits();
		logic [799:0] v;
		for (int i = 0; i < 25; i++)
			v[i*32 +: 32] = $random(seed);
		return v;
	endfunction

	function automatic seed_pkg::new_read_t rand_new_read();
		logic [799:0] v;
		v = rand_bits();
		return v[$bits(seed_pkg::new_read_t)-1:0];
	endfunction

	// fresh read as the loader hands it over
	function automatic seed_pkg::fwd_entry_t fresh_entry(seed_pkg::new_read_t n);
		seed_pkg::fwd_entry_t e;
		e.rec.ptr_curr   = '0;
		e.rec.read_num   = n.read_num;
		e.rec.ik_x0      = n.ik_x0;
		e.rec.ik_x1      = n.ik_x1;
		e.rec.ik_x2      = n.ik_x2;
		e.rec.ik_info_hi = n.ik_info_hi;
		e.rec.ik_info_lo = n.ik_info_lo;
		e.rec.forward_i  = n.forward_i + 1'b1;
		e.rec.min_intv   = n.min_intv;
		e.rec.backward_x = n.forward_i;
		e.query          = '0;
		e.status         = seed_pkg::F_INIT;
		return e;
	endfunction

	function automatic seed_pkg::fwd_out_t expected_out(seed_pkg::fwd_entry_t e);
		seed_pkg::fwd_out_t o;
		logic [63:0]        x1;
		logic [63:0]        x2;
		x1          = e.rec.ik_x1;  // zero extended
		x2          = e.rec.ik_x2;
		o.entry     = e;
		o.forward_k = x1 - 64'd1;
		o.forward_l = o.forward_k + x2;
		return o;
	endfunction

	task automatic check_output();
		seed_pkg::fwd_entry_t e;
		seed_pkg::fwd_out_t   x;
		occ_pkg::occ_resp_t   w;
		logic                 fresh;
		fresh = (fwd_out.entry.status == seed_pkg::F_INIT);
		chk_cnt++;
		assert (fresh ? fresh_q.size() != 0 : read_q.size() != 0) else begin
			$display("record came out at %0t with nothing pending to match it", $time);
			err_cnt++;
		end
		if (fresh ? fresh_q.size() == 0 : read_q.size() == 0)
			return;
		e = fresh ? fresh_q.pop_front() : read_q.pop_front();
		x = expected_out(e);
		assert (fwd_out === x) else begin
			$display("error %0t: read %0h status %0h k %0h, expected read %0h status %0h k %0h",
				$time, fwd_out.entry.rec.read_num, fwd_out.entry.status, fwd_out.forward_k,
				x.entry.rec.read_num, x.entry.status, x.forward_k);
			err_cnt++;
		end
		if (e.status == seed_pkg::F_RUN) begin
			assert (occ_q.size() != 0) else begin
				$display("F_RUN record at %0t left without any occurrence response", $time);
				err_cnt++;
			end
			if (occ_q.size() != 0) begin
				w = occ_q.pop_front();
				assert (occ_out === w) else begin
					$display("error %0t: occ_out does not match the FIFO-order response", $time);
					err_cnt++;
				end
			end
		end
	endtask

	//==================================================
	// monitor and compare
	//==================================================
	always @(posedge Clk_32UI)
		out_fresh <= reset_n && !stall;  // output may have moved at this edge

	always @(negedge Clk_32UI) begin
		if (reset_n && !stall && new_read_valid && !new_read)
			nr_gap_cnt++;
		if (new_read)
			fresh_q.push_back(fresh_entry(new_rd));
		if (out_fresh && fwd_out.entry.status != seed_pkg::BUBBLE)
			check_output();
	end

	task automatic push_record(input seed_pkg::status_t st);
		seed_pkg::fwd_entry_t e;
		logic [799:0]         v;
		v        = rand_bits();
		e.rec    = v[$bits(seed_pkg::fwd_rec_t)-1:0];
		e.query  = v[799 -: 8];
		e.status = st;
		@(posedge Clk_32UI);
		fwd_in              <= e.rec;
		fwd_status          <= st;
		query_base          <= e.query;
		next_query_position <= e.rec.ptr_curr;
		read_num_query      <= e.rec.read_num;
		status_query        <= st;
		read_q.push_back(e);
	endtask

	task automatic stop_records();
		@(posedge Clk_32UI);
		fwd_status <= seed_pkg::BUBBLE;
	endtask

	task automatic send_occ();
		logic [799:0]       v;
		occ_pkg::occ_resp_t w;
		v = rand_bits();
		w = v[$bits(occ_pkg::occ_resp_t)-1:0];
		@(posedge Clk_32UI);
		DRAM_get <= 1'b1;
		occ_in   <= w;
		occ_q.push_back(w);
		@(posedge Clk_32UI);
		DRAM_get <= 1'b0;
	endtask

	task automatic wait_drain(input string what);
		int n;
		n = 0;
		while (read_q.size() + fresh_q.size() + occ_q.size() != 0 && n < 200) begin
			@(posedge Clk_32UI);
			n++;
		end
		if (read_q.size() + fresh_q.size() + occ_q.size() != 0) begin
			$display("timeout in %s: %0d records and %0d responses never came out",
				what, read_q.size() + fresh_q.size(), occ_q.size());
			timed_out = 1'b1;
		end
	endtask

	task automatic wait_new_read();
		int n;
		n = 0;
		do begin
			@(negedge Clk_32UI);
			n++;
		end while (!new_read && n < 50);
		if (!new_read) begin
			$display("timeout: new_read never pulsed for a waiting fresh read");
			timed_out = 1'b1;
		end
	endtask

	task automatic end_test(input string name, input int errs_before);
		if (timed_out)
			$display("test %s: did not finish", name);
		else if (err_cnt == errs_before)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, err_cnt - errs_before);
	endtask

	//==================================================
	// test sequence
	//==================================================
	initial begin
		int                 e0;
		int                 runs;
		int                 sva_fail;
		seed_pkg::status_t  st;
		seed_pkg::fwd_out_t held;
		occ_pkg::occ_resp_t held_occ;
		reset_n = 1'b0;
		stall = 1'b0;
		DRAM_get = 1'b0;
		occ_in = '0;
		fwd_in = '0;
		fwd_status = seed_pkg::BUBBLE;
		next_query_position = '0;
		read_num_query = '0;
		status_query = seed_pkg::BUBBLE;
		new_read_query_2Queue = '0;
		new_read_valid = 1'b0;
		new_rd = '0;
		query_base = '0;
		base_dly1 = '0;
		base_dly2 = '0;
		repeat (2) @(posedge Clk_32UI);
		reset_n <= 1'b1;

		e0 = err_cnt;
		@(negedge Clk_32UI);
		chk_cnt++;
		assert (fwd_out.entry.status == seed_pkg::BUBBLE) else begin
			$display("error %0t: status %0h after reset", $time, fwd_out.entry.status);
			err_cnt++;
		end
		end_test("reset", e0);

		e0 = err_cnt;
		@(posedge Clk_32UI);
		new_read_valid <= 1'b1;
		new_rd         <= rand_new_read();
		wait_new_read();
		@(posedge Clk_32UI);
		new_read_valid <= 1'b0;
		if (!timed_out)
			wait_drain("fresh read");
		end_test("fresh read", e0);

		if (!timed_out) begin
			e0 = err_cnt;
			push_record(seed_pkg::F_RUN);
			stop_records();
			@(negedge Clk_32UI);
			chk_cnt++;
			assert (query_position_2RAM === next_query_position &&
				query_read_num_2RAM === read_num_query &&
				query_status_2RAM === status_query) else begin
				$display("error %0t: query outputs do not follow the query inputs", $time);
				err_cnt++;
			end
			send_occ();
			wait_drain("recirculation");
			end_test("recirculation", e0);
		end

		// two breaks under a steady stream of fresh reads
		if (!timed_out) begin
			e0 = err_cnt;
			@(posedge Clk_32UI);
			new_read_valid <= 1'b1;
			nr_gap_cnt = 0;
			push_record(seed_pkg::F_BREAK);
			push_record(seed_pkg::F_BREAK);
			stop_records();
			repeat (12) begin
				@(posedge Clk_32UI);
				new_rd <= rand_new_read();
			end
			new_read_valid <= 1'b0;
			wait_drain("break");
			chk_cnt++;
			assert (nr_gap_cnt == 2) else begin
				$display("error %0t: new_read held low %0d cycles, expected 2", $time, nr_gap_cnt);
				err_cnt++;
			end
			end_test("break", e0);
		end

		if (!timed_out) begin
			e0 = err_cnt;
			push_record(seed_pkg::F_RUN);
			stop_records();
			repeat (8) @(posedge Clk_32UI);
			stall          <= 1'b1;
			new_read_valid <= 1'b1;
			@(negedge Clk_32UI);
			held     = fwd_out;
			held_occ = occ_out;
			send_occ();  // taken although frozen
			repeat (4) begin
				@(negedge Clk_32UI);
				chk_cnt++;
				assert (fwd_out === held && occ_out === held_occ && !new_read) else begin
					$display("error %0t: output moved or new_read high during stall", $time);
					err_cnt++;
				end
			end
			@(posedge Clk_32UI);
			stall          <= 1'b0;
			new_read_valid <= 1'b0;
			wait_drain("stall");
			end_test("stall", e0);
		end

		if (!timed_out) begin
			e0 = err_cnt;
			runs = 0;
			for (int i = 0; i < 8; i++) begin
				st = ($random(seed) & 1) ? seed_pkg::F_RUN : seed_pkg::F_BREAK;
				if (st == seed_pkg::F_RUN)
					runs++;
				push_record(st);
			end
			stop_records();
			repeat (runs) send_occ();
			wait_drain("ordering");
			end_test("ordering", e0);
		end

		sva_fail = seed_queue_inst.read_queue_dispatch_inst.dispatch_sva_inst.fail_cnt;
		$display("%0d checks, %0d errors, %0d assertion failures", chk_cnt, err_cnt, sva_fail);
		if (err_cnt == 0 && sva_fail == 0 && !timed_out)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

// ==== tb_seed_queue_sva.sv ====
/*
 * Concurrent checks on the dispatcher control signals, bound into
 * read_queue_dispatch.
 */
module tb_seed_queue_sva (
	input logic              Clk_32UI,
	input logic              reset_n,
	input logic              stall,
	input logic              new_read,
	input seed_pkg::status_t head_status,
	input logic              occ_pop,
	input logic              occ_valid,
	input seed_pkg::status_t out_status
);
	timeunit 1ns;
	timeprecision 100ps;

	int unsigned fail_cnt = 0;

	nr_stall_a: assert property (@(posedge Clk_32UI) disable iff (!reset_n)
		stall |-> !new_read)
		else begin
			$error("new_read high during stall");
			fail_cnt++;
		end

	// break at head always wins over a fresh read
	nr_break_a: assert property (@(posedge Clk_32UI) disable iff (!reset_n)
		(head_status == seed_pkg::F_BREAK) |-> !new_read)
		else begin
			$error("new_read high with F_BREAK at the queue head");
			fail_cnt++;
		end

	pop_valid_a: assert property (@(posedge Clk_32UI) disable iff (!reset_n)
		occ_pop |-> occ_valid)
		else begin
			$error("occ_pop on an empty occurrence FIFO");
			fail_cnt++;
		end

	reset_bubble_a: assert property (@(posedge Clk_32UI)
		!reset_n |=> (out_status == seed_pkg::BUBBLE))
		else begin
			$error("output status not BUBBLE after reset");
			fail_cnt++;
		end

endmodule

bind read_queue_dispatch tb_seed_queue_sva dispatch_sva_inst (
	.Clk_32UI    (Clk_32UI),
	.reset_n     (reset_n),
	.stall       (stall),
	.new_read    (new_read),
	.head_status (head_status),
	.occ_pop     (occ_pop),
	.occ_valid   (occ_valid),
	.out_status  (fwd_out.entry.status)
);
